// File: flist.f
rtl/ro_pkg.sv
rtl/free_list.sv
rtl/ro_request_split.sv
rtl/ro_tag_table.sv
rtl/ro_response_unpack.sv
rtl/ro_read_stage.sv
test/tb_clock.sv
test/ro_checker.sv
test/tb_ro_read_stage.sv

// File: test/tb_ro_read_stage.sv
module tb_ro_read_stage import ro_pkg::*; ();

   localparam int NUM_REQ        = 200;
   localparam int LINES_PER_READ = 3;   // 32 words from mid-line touch 3 lines
   localparam int TIMEOUT_CYCLES = NUM_REQ * (MAX_LEN + 16 * LINES_PER_READ + 10);

   logic        clk;
   logic        rstn;
   logic        req_valid;
   logic        req_ready;
   logic [31:0] req_addr;
   req_len_t    req_len;
   ctx_t        req_ctx;
   logic        arvalid;
   logic        arready = 1'b0;
   logic [31:0] araddr;
   arid_t       arid;
   logic        rvalid = 1'b0;
   logic        rready;
   arid_t       rid = '0;
   line_t       rdata = '0;
   logic        out_valid;
   logic        out_ready = 1'b0;
   word_t       out_data;
   ctx_t        out_ctx;
   word_id_t    out_word_id;
   logic        out_last;
   logic        idle;

   int          phase;
   logic        run_done;
   int          errors;
   int          checked;
   int          pending;

   // memory model, answers in the order of the bus reads
   logic [31:0] mem_addr_q [$];
   arid_t       mem_id_q   [$];
   int          mem_due_q  [$];
   int          last_due;
   int          cycles;
   int          out_ready_pct = 100;
   int          arready_pct   = 100;
   int          delay_min     = 1;
   int          delay_max     = 8;

   tb_clock #(.PERIOD(10)) clock_i (.clk(clk));

   ro_read_stage dut_i (.*);

   ro_checker checker_i (.*);

   function automatic line_t make_line(input logic [31:0] addr);
      line_t       line;
      logic [31:0] base;
      base = {addr[31:6], 6'b0};
      for (int k = 0; k < LINE_WORDS; k++) begin
         line[k*WORD_BITS +: WORD_BITS] = (base + 32'(4 * k)) * 32'd40503;
      end
      return line;
   endfunction

   function automatic logic [31:0] rand_addr();
      return 32'($urandom_range(32'hffff, 0)) << 2;   // word aligned
   endfunction

   always @(posedge clk) begin : mem_accept
      int due;
      if (arvalid && arready) begin
         due = cycles + $urandom_range(delay_max, delay_min);
         if (due < last_due) begin
            due = last_due;   // keep responses in order
         end
         last_due = due;
         mem_addr_q.push_back(araddr);
         mem_id_q.push_back(arid);
         mem_due_q.push_back(due);
      end
      if (rvalid && rready) begin
         void'(mem_addr_q.pop_front());
         void'(mem_id_q.pop_front());
         void'(mem_due_q.pop_front());
      end
      cycles = cycles + 1;
   end

   always @(negedge clk) begin
      out_ready = ($urandom_range(99, 0) < out_ready_pct);
      arready   = ($urandom_range(99, 0) < arready_pct);
      if (mem_addr_q.size() > 0 && cycles >= mem_due_q[0]) begin
         rvalid = 1'b1;
         rid    = mem_id_q[0];
         rdata  = make_line(mem_addr_q[0]);
      end else begin
         rvalid = 1'b0;
      end
   end

   task automatic wait_drain();
      while (pending != 0) begin
         @(posedge clk);
      end
   endtask

   task automatic start_phase(input int p, input int o_pct, input int a_pct,
                              input int dmin, input int dmax);
      wait_drain();
      @(posedge clk);
      out_ready_pct = o_pct;
      arready_pct   = a_pct;
      delay_min     = dmin;
      delay_max     = dmax;
      @(negedge clk);
      phase = p;
   endtask

   // starts and ends on a falling edge
   task automatic send_req(input logic [31:0] addr, input int len, input int gap);
      logic accepted;
      req_valid = 1'b1;
      req_addr  = addr;
      req_len   = req_len_t'(len);
      req_ctx   = ctx_t'($urandom);
      accepted  = 1'b0;
      while (!accepted) begin
         @(posedge clk);
         accepted = req_ready;
      end
      @(negedge clk);
      req_valid = 1'b0;
      repeat (gap) @(negedge clk);
   endtask

   task automatic send_line_cross();
      int          off;
      logic [31:0] base;
      off  = $urandom_range(15, 1);
      base = rand_addr() & ~32'h3f;
      send_req(base | 32'(off << 2), $urandom_range(32, 17 - off), $urandom_range(2, 0));
   endtask

   initial begin
      void'($urandom(9374));
      rstn      = 1'b0;
      req_valid = 1'b0;
      req_addr  = '0;
      req_len   = '0;
      req_ctx   = '0;
      phase     = 0;
      run_done  = 1'b0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;

      start_phase(1, 100, 100, 1, 8);
      repeat (10) send_req(rand_addr(), 1, $urandom_range(3, 0));

      start_phase(2, 100, 100, 1, 8);
      repeat (30) send_line_cross();

      start_phase(3, 60, 70, 1, 8);
      repeat (100) send_req(rand_addr(), $urandom_range(32, 1), $urandom_range(4, 0));

      // slow memory and a slow consumer use up the thread pool
      start_phase(4, 40, 100, 8, 8);
      repeat (60) send_req(rand_addr(), $urandom_range(32, 1), 0);

      wait_drain();
      repeat (20) @(posedge clk);   // catch stray output words
      @(negedge clk);
      run_done = 1'b1;
      repeat (2) @(posedge clk);
      @(negedge clk);
      $display("errors: %0d, words checked: %0d, words missing: %0d",
               errors, checked, pending);
      if (errors == 0 && pending == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   initial begin : watchdog
      int count;
      count = 0;
      while (count < TIMEOUT_CYCLES) begin
         @(posedge clk);
         count++;
      end
      $display("timeout: run did not finish within %0d cycles, %0d words still expected",
               TIMEOUT_CYCLES, pending);
      $display("errors: %0d, words checked: %0d, words missing: %0d",
               errors, checked, pending);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

// File: test/ro_checker.sv
module ro_checker import ro_pkg::*; (
   input  logic        clk,
   input  logic        rstn,
   input  int          phase,
   input  logic        run_done,

   input  logic        req_valid,
   input  logic        req_ready,
   input  logic [31:0] req_addr,
   input  req_len_t    req_len,
   input  ctx_t        req_ctx,

   input  logic        arvalid,
   input  logic        arready,
   input  logic [31:0] araddr,

   input  logic        out_valid,
   input  logic        out_ready,
   input  word_t       out_data,
   input  ctx_t        out_ctx,
   input  word_id_t    out_word_id,
   input  logic        out_last,
   input  logic        idle,

   output int          errors,
   output int          checked,
   output int          pending
);

   // expected words in output order
   word_t    exp_data_q  [$];
   ctx_t     exp_ctx_q   [$];
   int       exp_id_q    [$];
   logic     exp_last_q  [$];
   int       exp_phase_q [$];

   logic [31:0] exp_addr_q [$];   // expected bus-read addresses in issue order

   int       err_count;
   int       n_checked;
   int       outstanding;   // accepted reads whose last word has not left
   bit       reported;

   // word offered last cycle but not taken
   bit       stalled;
   word_t    held_data;
   ctx_t     held_ctx;
   word_id_t held_id;
   logic     held_last;

   function automatic string test_name(input int p);
      case (p)
         0:       return "after_reset";
         1:       return "one_word";
         2:       return "line_cross";
         3:       return "random_ready";
         4:       return "slow_memory";
         default: return "unknown";
      endcase
   endfunction

   task automatic check_value(input string test, input string field,
                              input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("CHECK FAILED %s %s: expected %0h actual %0h", test, field, exp, act);
         err_count++;
      end
   endtask

   always @(posedge clk) begin : watch
      logic [31:0] waddr;
      logic [31:0] baddr;
      int          left;
      int          room;
      if (rstn) begin
         // a thread is busy exactly while its read is outstanding
         check_value(test_name(phase), "idle", 32'(outstanding == 0), 32'(idle));

         if (stalled && (!out_valid || out_data !== held_data || out_ctx !== held_ctx ||
                         out_word_id !== held_id || out_last !== held_last)) begin
            $display("output word changed or vanished while out_ready was low");
            err_count++;
         end

         if (arvalid && arready) begin
            if (exp_addr_q.size() == 0) begin
               $display("bus read at %0h issued with no read pending", araddr);
               err_count++;
            end else begin
               check_value(test_name(phase), "araddr", exp_addr_q[0], araddr);
               void'(exp_addr_q.pop_front());
            end
         end

         if (out_valid && out_ready) begin
            if (exp_data_q.size() == 0) begin
               $display("output word %0h came out with no word expected", out_data);
               err_count++;
            end else begin
               check_value(test_name(exp_phase_q[0]), "data", exp_data_q[0], out_data);
               check_value(test_name(exp_phase_q[0]), "ctx", 32'(exp_ctx_q[0]), 32'(out_ctx));
               check_value(test_name(exp_phase_q[0]), "word_id", 32'(exp_id_q[0]),
                           32'(out_word_id));
               check_value(test_name(exp_phase_q[0]), "last", 32'(exp_last_q[0]),
                           32'(out_last));
               void'(exp_data_q.pop_front());
               void'(exp_ctx_q.pop_front());
               void'(exp_id_q.pop_front());
               void'(exp_last_q.pop_front());
               void'(exp_phase_q.pop_front());
               n_checked++;
            end
            if (out_last) begin
               outstanding--;
            end
         end

         if (req_valid && req_ready) begin
            for (int i = 0; i < int'(req_len); i++) begin
               waddr = req_addr + 32'(4 * i);
               exp_data_q.push_back(waddr * 32'd40503);
               exp_ctx_q.push_back(req_ctx);
               exp_id_q.push_back(i);
               exp_last_q.push_back(i == int'(req_len) - 1);
               exp_phase_q.push_back(phase);
            end
            // one bus read per line touched, later ones from the line start
            baddr = req_addr;
            left  = int'(req_len);
            while (left > 0) begin
               exp_addr_q.push_back(baddr);
               room  = LINE_WORDS - int'(baddr[5:2]);
               left  = left - room;
               baddr = {baddr[31:6] + 26'd1, 6'b0};
            end
            outstanding++;
         end

         if (outstanding > 8) begin
            $display("%0d reads accepted but not finished, only 8 threads exist", outstanding);
            err_count++;
         end

         stalled   = out_valid && !out_ready;
         held_data = out_data;
         held_ctx  = out_ctx;
         held_id   = out_word_id;
         held_last = out_last;

         if (run_done && !reported) begin
            reported = 1'b1;
            if (exp_data_q.size() != 0) begin
               $display("%0d expected words never came out, the first from test %s",
                        exp_data_q.size(), test_name(exp_phase_q[0]));
               err_count++;
            end
         end
      end
      errors  <= err_count;
      checked <= n_checked;
      pending <= exp_data_q.size();
   end

endmodule

// File: test/tb_clock.sv
module tb_clock #(
   parameter int PERIOD = 10
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD / 2) clk = ~clk;
      end
   end

endmodule

// File: rtl/ro_read_stage.sv
module ro_read_stage import ro_pkg::*; (
   input  logic        clk,
   input  logic        rstn,

   input  logic        req_valid,
   output logic        req_ready,
   input  logic [31:0] req_addr,
   input  req_len_t    req_len,
   input  ctx_t        req_ctx,

   output logic        arvalid,
   input  logic        arready,
   output logic [31:0] araddr,
   output arid_t       arid,

   input  logic        rvalid,
   output logic        rready,
   input  arid_t       rid,
   input  line_t       rdata,

   output logic        out_valid,
   input  logic        out_ready,
   output word_t       out_data,
   output ctx_t        out_ctx,
   output word_id_t    out_word_id,
   output logic        out_last,

   output logic        idle
);

   logic       arid_avail;
   thread_t    entry_thread;
   word_mask_t entry_mask;
   word_id_t   entry_start;

   thread_t    hit_thread;
   word_mask_t hit_mask;
   word_id_t   hit_start;

   logic       start_valid;
   thread_t    start_thread;
   ctx_t       start_ctx;
   req_len_t   start_len;

   logic       done_valid;
   thread_t    done_thread;

   ro_request_split split_i (
      .clk          (clk),
      .rstn         (rstn),
      .req_valid    (req_valid),
      .req_ready    (req_ready),
      .req_addr     (req_addr),
      .req_len      (req_len),
      .req_ctx      (req_ctx),
      .arvalid      (arvalid),
      .arready      (arready),
      .araddr       (araddr),
      .arid_avail   (arid_avail),
      .entry_thread (entry_thread),
      .entry_mask   (entry_mask),
      .entry_start  (entry_start),
      .start_valid  (start_valid),
      .start_thread (start_thread),
      .start_ctx    (start_ctx),
      .start_len    (start_len),
      .done_valid   (done_valid),
      .done_thread  (done_thread),
      .idle         (idle)
   );

   ro_tag_table tags_i (
      .clk          (clk),
      .rstn         (rstn),
      .arvalid      (arvalid),
      .arready      (arready),
      .arid         (arid),
      .arid_avail   (arid_avail),
      .entry_thread (entry_thread),
      .entry_mask   (entry_mask),
      .entry_start  (entry_start),
      .rvalid       (rvalid),
      .rready       (rready),
      .rid          (rid),
      .hit_thread   (hit_thread),
      .hit_mask     (hit_mask),
      .hit_start    (hit_start)
   );

   ro_response_unpack unpack_i (
      .clk          (clk),
      .rstn         (rstn),
      .rvalid       (rvalid),
      .rready       (rready),
      .rdata        (rdata),
      .hit_thread   (hit_thread),
      .hit_mask     (hit_mask),
      .hit_start    (hit_start),
      .start_valid  (start_valid),
      .start_thread (start_thread),
      .start_ctx    (start_ctx),
      .start_len    (start_len),
      .out_valid    (out_valid),
      .out_ready    (out_ready),
      .out_data     (out_data),
      .out_ctx      (out_ctx),
      .out_word_id  (out_word_id),
      .out_last     (out_last),
      .done_valid   (done_valid),
      .done_thread  (done_thread)
   );

endmodule

// File: rtl/ro_response_unpack.sv
module ro_response_unpack import ro_pkg::*; (
   input  logic       clk,
   input  logic       rstn,

   input  logic       rvalid,
   output logic       rready,
   input  line_t      rdata,
   input  thread_t    hit_thread,
   input  word_mask_t hit_mask,
   input  word_id_t   hit_start,

   input  logic       start_valid,
   input  thread_t    start_thread,
   input  ctx_t       start_ctx,
   input  req_len_t   start_len,

   output logic       out_valid,
   input  logic       out_ready,
   output word_t      out_data,
   output ctx_t       out_ctx,
   output word_id_t   out_word_id,
   output logic       out_last,

   output logic       done_valid,
   output thread_t    done_thread
);

   // held line
   logic       held;
   line_t      line_q;
   word_mask_t mask_q;
   word_id_t   word_id_q;
   thread_t    thread_q;

   // per-thread state, written when a read is accepted
   ctx_t       ctx_tab [2**THREAD_LOG];
   req_len_t   rem_tab [2**THREAD_LOG];

   line_idx_t  pos;
   word_mask_t next_mask;
   logic       line_done;
   logic       out_hs;
   logic       r_hs;

   // lowest wanted word still in the line
   always_comb begin
      pos = '0;
      for (int i = LINE_WORDS - 1; i >= 0; i--) begin
         if (mask_q[i]) begin
            pos = line_idx_t'(i);
         end
      end
   end

   assign next_mask = mask_q & (mask_q - 1'b1);   // drops the lowest set bit
   assign line_done = (next_mask == '0);

   assign out_valid   = held;
   assign out_data    = line_q[pos*WORD_BITS +: WORD_BITS];
   assign out_ctx     = ctx_tab[thread_q];
   assign out_word_id = word_id_q;
   assign out_last    = (rem_tab[thread_q] == req_len_t'(1));

   assign out_hs = out_valid && out_ready;
   assign rready = !held || (out_hs && line_done);
   assign r_hs   = rvalid && rready;

   assign done_valid  = out_hs && out_last;
   assign done_thread = thread_q;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         held <= 1'b0;
      end else if (r_hs) begin
         held <= 1'b1;
      end else if (out_hs && line_done) begin
         held <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (r_hs) begin
         line_q    <= rdata;
         mask_q    <= hit_mask;
         word_id_q <= hit_start;
         thread_q  <= hit_thread;
      end else if (out_hs) begin
         mask_q    <= next_mask;
         word_id_q <= word_id_q + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (out_hs) begin
         rem_tab[thread_q] <= rem_tab[thread_q] - 1'b1;
      end
      // a thread is restarted only after its last word has left
      if (start_valid) begin
         ctx_tab[start_thread] <= start_ctx;
         rem_tab[start_thread] <= start_len;
      end
   end

endmodule

// File: rtl/ro_tag_table.sv
module ro_tag_table import ro_pkg::*; (
   input  logic       clk,
   input  logic       rstn,

   input  logic       arvalid,
   input  logic       arready,
   output arid_t      arid,
   output logic       arid_avail,
   input  thread_t    entry_thread,
   input  word_mask_t entry_mask,
   input  word_id_t   entry_start,

   input  logic       rvalid,
   input  logic       rready,
   input  arid_t      rid,
   output thread_t    hit_thread,
   output word_mask_t hit_mask,
   output word_id_t   hit_start
);

   thread_t    thread_tab [2**ARID_LOG];
   word_mask_t mask_tab   [2**ARID_LOG];
   word_id_t   start_tab  [2**ARID_LOG];
   logic       id_empty;

   free_list #(
      .LOG_DEPTH(ARID_LOG)
   ) arid_pool (
      .clk     (clk),
      .rstn    (rstn),
      .wr_en   (rvalid && rready),   // id comes back with its response
      .wr_data (rid),
      .rd_en   (arvalid && arready),
      .rd_data (arid),
      .empty   (id_empty),
      .full    ()
   );

   assign arid_avail = !id_empty;

   always_ff @(posedge clk) begin
      if (arvalid && arready) begin
         thread_tab[arid] <= entry_thread;
         mask_tab[arid]   <= entry_mask;
         start_tab[arid]  <= entry_start;
      end
   end

   assign hit_thread = thread_tab[rid];
   assign hit_mask   = mask_tab[rid];
   assign hit_start  = start_tab[rid];

endmodule

// File: rtl/ro_request_split.sv
module ro_request_split import ro_pkg::*; (
   input  logic        clk,
   input  logic        rstn,

   input  logic        req_valid,
   output logic        req_ready,
   input  logic [31:0] req_addr,
   input  req_len_t    req_len,
   input  ctx_t        req_ctx,

   output logic        arvalid,
   input  logic        arready,
   output logic [31:0] araddr,
   input  logic        arid_avail,

   output thread_t     entry_thread,
   output word_mask_t  entry_mask,
   output word_id_t    entry_start,

   output logic        start_valid,
   output thread_t     start_thread,
   output ctx_t        start_ctx,
   output req_len_t    start_len,

   input  logic        done_valid,
   input  thread_t     done_thread,
   output logic        idle
);

   ar_state_e   state;
   logic [31:0] cur_addr;
   req_len_t    rem;        // words still to be requested
   word_id_t    word_idx;   // index of the next word within the read
   thread_t     cur_thread;

   line_idx_t   line_pos;
   req_len_t    line_room;
   req_len_t    chunk;
   logic        last_burst;
   logic        ar_hs;
   logic        accept;
   logic        thr_empty;
   thread_t     thr_next;

   assign line_pos   = cur_addr[5:2];
   assign line_room  = req_len_t'(LINE_WORDS) - req_len_t'(line_pos);
   assign chunk      = (rem < line_room) ? rem : line_room;
   assign last_burst = (rem <= line_room);

   assign arvalid   = (state == AR_BURST) && arid_avail;
   assign ar_hs     = arvalid && arready;
   assign req_ready = !thr_empty && ((state == AR_IDLE) || (ar_hs && last_burst));
   assign accept    = req_valid && req_ready;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= AR_IDLE;
      end else if (accept) begin
         state <= AR_BURST;
      end else if (ar_hs && last_burst) begin
         state <= AR_IDLE;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         cur_addr   <= req_addr;
         rem        <= req_len;
         word_idx   <= '0;
         cur_thread <= thr_next;
      end else if (ar_hs && !last_burst) begin
         cur_addr <= cur_addr + (32'(chunk) << 2);   // next line start
         rem      <= rem - chunk;
         word_idx <= word_idx + word_id_t'(chunk);
      end
   end

   // words covered by this bus read, within the line
   always_comb begin
      for (int i = 0; i < LINE_WORDS; i++) begin
         entry_mask[i] = (req_len_t'(i) >= req_len_t'(line_pos)) &&
                         (req_len_t'(i) < req_len_t'(line_pos) + chunk);
      end
   end

   assign araddr       = cur_addr;
   assign entry_thread = cur_thread;
   assign entry_start  = word_idx;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         start_valid <= 1'b0;
      end else begin
         start_valid <= accept;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         start_thread <= thr_next;
         start_ctx    <= req_ctx;
         start_len    <= req_len;
      end
   end

   free_list #(
      .LOG_DEPTH(THREAD_LOG)
   ) thread_pool (
      .clk     (clk),
      .rstn    (rstn),
      .wr_en   (done_valid),
      .wr_data (done_thread),
      .rd_en   (accept),
      .rd_data (thr_next),
      .empty   (thr_empty),
      .full    (idle)      // every thread back in the pool
   );

endmodule

// File: rtl/free_list.sv
module free_list #(
   parameter int LOG_DEPTH = 5
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 wr_en,
   input  logic [LOG_DEPTH-1:0] wr_data,
   input  logic                 rd_en,
   output logic [LOG_DEPTH-1:0] rd_data,
   output logic                 empty,
   output logic                 full
);

   logic [LOG_DEPTH-1:0] mem [2**LOG_DEPTH];
   logic [LOG_DEPTH-1:0] rd_ptr;
   logic [LOG_DEPTH-1:0] wr_ptr;
   logic [LOG_DEPTH:0]   count;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         // every id starts out free
         for (int i = 0; i < 2**LOG_DEPTH; i++) begin
            mem[i] <= i[LOG_DEPTH-1:0];
         end
         rd_ptr <= '0;
         wr_ptr <= '0;   // buffer is full, so write side wraps onto read side
         count  <= (LOG_DEPTH+1)'(2**LOG_DEPTH);
      end else begin
         if (wr_en) begin
            mem[wr_ptr] <= wr_data;
            wr_ptr      <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign rd_data = mem[rd_ptr];   // oldest free id
   assign empty   = (count == '0);
   assign full    = (count == (LOG_DEPTH+1)'(2**LOG_DEPTH));

endmodule

// File: rtl/ro_pkg.sv
package ro_pkg;

   localparam int WORD_BITS  = 32;
   localparam int LINE_WORDS = 16;
   localparam int MAX_LEN    = 32;
   localparam int ARID_LOG   = 5;
   localparam int THREAD_LOG = 3;

   typedef logic [WORD_BITS-1:0]               word_t;
   typedef logic [LINE_WORDS*WORD_BITS-1:0]    line_t;      // one 64-byte line
   typedef logic [LINE_WORDS-1:0]              word_mask_t;
   typedef logic [$clog2(LINE_WORDS)-1:0]      line_idx_t;

   // length needs one more bit than an index so that MAX_LEN fits
   typedef logic [$clog2(MAX_LEN+1)-1:0]       req_len_t;
   typedef logic [$clog2(MAX_LEN)-1:0]         word_id_t;

   typedef logic [15:0]                        ctx_t;
   typedef logic [ARID_LOG-1:0]                arid_t;
   typedef logic [THREAD_LOG-1:0]              thread_t;

   typedef enum logic [0:0] {
      AR_IDLE,
      AR_BURST   // issuing line reads for the current request
   } ar_state_e;

endpackage
